//--- logic/sfir_pkg.sv
// default widths, tap count, buffer depths and coefficient set of the FIR filter.

package sfir_pkg;

    // the impulse response is twice as long as the number of unique coefficients.
    localparam int SFIR_TAP_NUM = 8;

    localparam int SFIR_DATA_WIDTH = 16;
    localparam int SFIR_COEF_WIDTH = 16;

    // one bit for the pre-adder and log2 of the tap count for the cascade sum.
    localparam int SFIR_ACC_WIDTH = SFIR_DATA_WIDTH + SFIR_COEF_WIDTH + 1 + $clog2(SFIR_TAP_NUM);

    // the input depth is also the number of credits the sender holds after reset.
    localparam int SFIR_IN_DEPTH = 4;
    localparam int SFIR_OUT_DEPTH = 4;

    // the first half of a symmetric low-pass response ends with the centre taps.
    localparam int SFIR_COEF [0:SFIR_TAP_NUM-1] = '{
        -142,
        310,
        -604,
        1021,
        -1688,
        2890,
        -5470,
        16384
    };

endpackage

//--- logic/sfir_input_buffer.sv
// credit-issuing sample FIFO that feeds the filter pipeline.
`timescale 1ns/1ns

module sfir_input_buffer #(
    parameter int IN_DEPTH   = sfir_pkg::SFIR_IN_DEPTH,
    parameter int DATA_WIDTH = sfir_pkg::SFIR_DATA_WIDTH
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         in_valid_i,
    input  logic signed [DATA_WIDTH-1:0] in_data_i,
    output logic                         in_credit_o,
    input  logic                         step_i,
    output logic                         smp_avail_o,
    output logic signed [DATA_WIDTH-1:0] smp_data_o
);

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);

    logic signed [DATA_WIDTH-1:0] mem [IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             credit_q;
    logic             pop;

    assign pop         = step_i && smp_avail_o;
    assign smp_avail_o = (cnt_q != '0);
    assign smp_data_o  = mem[rd_ptr_q];
    assign in_credit_o = credit_q;

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            mem[wr_ptr_q] <= in_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
            credit_q <= 1'b0;
        end else begin
            if (in_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({in_valid_i, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
            // every sample that leaves the FIFO hands one credit back.
            credit_q <= pop;
        end
    end

    // a sender that respects its credits never finds the FIFO full.
    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        in_valid_i |-> (int'(cnt_q) < IN_DEPTH)
    ) else $error("sample arrived with the input FIFO full, sender has no credit");

endmodule

//--- logic/sfir_delay_line.sv
// step-enabled shift register that supplies the folded sample to all taps.
`timescale 1ns/1ns

module sfir_delay_line #(
    parameter int TAP_NUM    = sfir_pkg::SFIR_TAP_NUM,
    parameter int DATA_WIDTH = sfir_pkg::SFIR_DATA_WIDTH
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         step_i,
    input  logic signed [DATA_WIDTH-1:0] data_i,
    output logic signed [DATA_WIDTH-1:0] folded_o
);

    // two skew registers per tap plus the extra stage in front of the pre-adder.
    localparam int DEPTH = 2 * TAP_NUM + 1;

    logic signed [DATA_WIDTH-1:0] sr_q [DEPTH];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                sr_q[i] <= '0;
            end
        end else if (step_i) begin
            sr_q[0] <= data_i;
            for (int i = 1; i < DEPTH; i++) begin
                sr_q[i] <= sr_q[i-1];
            end
        end
    end

    assign folded_o = sr_q[DEPTH-1];

endmodule

//--- logic/sfir_tap.sv
// systolic tap with data skew, pre-adder, coefficient multiplier and cascade adder.
`timescale 1ns/1ns

module sfir_tap #(
    parameter int DATA_WIDTH = sfir_pkg::SFIR_DATA_WIDTH,
    parameter int COEF_WIDTH = sfir_pkg::SFIR_COEF_WIDTH,
    parameter int ACC_WIDTH  = sfir_pkg::SFIR_ACC_WIDTH,
    parameter int COEF_VAL   = sfir_pkg::SFIR_COEF[0]
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         step_i,
    input  logic signed [DATA_WIDTH-1:0] data_i,
    input  logic signed [DATA_WIDTH-1:0] folded_i,
    input  logic signed [ACC_WIDTH-1:0]  casc_i,
    output logic signed [DATA_WIDTH-1:0] data_o,
    output logic signed [ACC_WIDTH-1:0]  casc_o
);

    localparam int PRE_W  = DATA_WIDTH + 1;
    localparam int PROD_W = PRE_W + COEF_WIDTH;
    localparam logic signed [COEF_WIDTH-1:0] COEF_S = COEF_WIDTH'(COEF_VAL);

    logic signed [DATA_WIDTH-1:0] d1_q;
    logic signed [DATA_WIDTH-1:0] d2_q;
    logic signed [PRE_W-1:0]      pre_q;
    logic signed [PROD_W-1:0]     prod_q;
    logic signed [ACC_WIDTH-1:0]  casc_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            d1_q   <= '0;
            d2_q   <= '0;
            pre_q  <= '0;
            prod_q <= '0;
            casc_q <= '0;
        end else if (step_i) begin
            d1_q   <= data_i;
            d2_q   <= d1_q;
            // the folded sample is the mirrored partner of the skewed one.
            pre_q  <= PRE_W'(d2_q) + PRE_W'(folded_i);
            prod_q <= pre_q * COEF_S;
            casc_q <= casc_i + ACC_WIDTH'(prod_q);
        end
    end

    assign data_o = d2_q;
    assign casc_o = casc_q;

endmodule

//--- logic/sfir_output_buffer.sv
// result FIFO with sink credit counter and pipeline advance control.
`timescale 1ns/1ns

module sfir_output_buffer #(
    parameter int OUT_DEPTH = sfir_pkg::SFIR_OUT_DEPTH,
    parameter int ACC_WIDTH = sfir_pkg::SFIR_ACC_WIDTH
) (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        step_i,
    input  logic signed [ACC_WIDTH-1:0] result_i,
    output logic                        out_ready_o,
    input  logic                        out_credit_i,
    output logic                        out_valid_o,
    output logic signed [ACC_WIDTH-1:0] out_data_o
);

    localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int CNT_W = $clog2(OUT_DEPTH + 1);
    localparam int CR_W  = $clog2(2 * OUT_DEPTH + 2);

    logic signed [ACC_WIDTH-1:0] mem [OUT_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic [CR_W-1:0]  cr_q;
    logic             push_q;

    // the chain result settles one cycle after the step that produced it.
    assign out_ready_o = (int'(cnt_q) + int'(push_q)) < OUT_DEPTH;
    assign out_valid_o = (cnt_q != '0) && (cr_q != '0);
    assign out_data_o  = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_q) begin
            mem[wr_ptr_q] <= result_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            push_q   <= 1'b0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
            cr_q     <= '0;
        end else begin
            push_q <= step_i;
            if (push_q) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (out_valid_o) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_q, out_valid_o})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
            case ({out_credit_i, out_valid_o})
                2'b10:   cr_q <= cr_q + 1'b1;
                2'b01:   cr_q <= cr_q - 1'b1;
                default: cr_q <= cr_q;
            endcase
        end
    end

    // out_ready_o one cycle earlier must have left room for this push.
    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        push_q |-> (int'(cnt_q) < OUT_DEPTH)
    ) else $error("result pushed into a full output FIFO");

    // the sink grants credits only for slots it has free on its side.
    a_credit_bound : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        int'(cr_q) <= OUT_DEPTH + int'(cnt_q) + int'(push_q)
    ) else $error("sink granted more output credits than it can hold");

endmodule

//--- logic/sfir_top.sv
// credit-controlled even-symmetric systolic FIR with buffers, delay line and tap chain.
`timescale 1ns/1ns

module sfir_top #(
    parameter int TAP_NUM              = sfir_pkg::SFIR_TAP_NUM,
    parameter int DATA_WIDTH           = sfir_pkg::SFIR_DATA_WIDTH,
    parameter int COEF_WIDTH           = sfir_pkg::SFIR_COEF_WIDTH,
    parameter int ACC_WIDTH            = sfir_pkg::SFIR_ACC_WIDTH,
    parameter int IN_DEPTH             = sfir_pkg::SFIR_IN_DEPTH,
    parameter int OUT_DEPTH            = sfir_pkg::SFIR_OUT_DEPTH,
    parameter int COEF [0:TAP_NUM-1]   = sfir_pkg::SFIR_COEF
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         in_valid_i,
    input  logic signed [DATA_WIDTH-1:0] in_data_i,
    output logic                         in_credit_o,
    output logic                         out_valid_o,
    output logic signed [ACC_WIDTH-1:0]  out_data_o,
    input  logic                         out_credit_i
);

    if ((TAP_NUM % 2) != 0) begin : g_tap_num_err
        $error("TAP_NUM must be even");
    end

    logic                         smp_avail;
    logic signed [DATA_WIDTH-1:0] smp_data;
    logic                         out_ready;
    logic                         step;
    logic signed [DATA_WIDTH-1:0] folded_data;
    logic signed [DATA_WIDTH-1:0] tap_data [TAP_NUM];
    logic signed [ACC_WIDTH-1:0]  tap_casc [TAP_NUM+1];

    // the whole pipeline moves only when a sample is there and the result has room.
    assign step        = smp_avail && out_ready;
    assign tap_data[0] = smp_data;
    assign tap_casc[0] = '0;

    sfir_input_buffer #(
        .IN_DEPTH  (IN_DEPTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) u_input_buffer (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .in_valid_i (in_valid_i),
        .in_data_i  (in_data_i),
        .in_credit_o(in_credit_o),
        .step_i     (step),
        .smp_avail_o(smp_avail),
        .smp_data_o (smp_data)
    );

    sfir_delay_line #(
        .TAP_NUM   (TAP_NUM),
        .DATA_WIDTH(DATA_WIDTH)
    ) u_delay_line (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .step_i  (step),
        .data_i  (smp_data),
        .folded_o(folded_data)
    );

    for (genvar i = 0; i < TAP_NUM; i++) begin : g_tap
        if (i < TAP_NUM - 1) begin : g_mid
            sfir_tap #(
                .DATA_WIDTH(DATA_WIDTH),
                .COEF_WIDTH(COEF_WIDTH),
                .ACC_WIDTH (ACC_WIDTH),
                .COEF_VAL  (COEF[i])
            ) u_tap (
                .clk_i   (clk_i),
                .arst_n_i(arst_n_i),
                .step_i  (step),
                .data_i  (tap_data[i]),
                .folded_i(folded_data),
                .casc_i  (tap_casc[i]),
                .data_o  (tap_data[i+1]),
                .casc_o  (tap_casc[i+1])
            );
        end else begin : g_last
            // only the cascade sum goes on from the last tap.
            sfir_tap #(
                .DATA_WIDTH(DATA_WIDTH),
                .COEF_WIDTH(COEF_WIDTH),
                .ACC_WIDTH (ACC_WIDTH),
                .COEF_VAL  (COEF[i])
            ) u_tap (
                .clk_i   (clk_i),
                .arst_n_i(arst_n_i),
                .step_i  (step),
                .data_i  (tap_data[i]),
                .folded_i(folded_data),
                .casc_i  (tap_casc[i]),
                .data_o  (),
                .casc_o  (tap_casc[i+1])
            );
        end
    end

    sfir_output_buffer #(
        .OUT_DEPTH(OUT_DEPTH),
        .ACC_WIDTH(ACC_WIDTH)
    ) u_output_buffer (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .step_i      (step),
        .result_i    (tap_casc[TAP_NUM]),
        .out_ready_o (out_ready),
        .out_credit_i(out_credit_i),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o)
    );

endmodule

//--- dv/sfir_tb.sv
// testbench with credit sender, credit sink, reference model, checks and tests.
`timescale 1ns/1ns

module sfir_tb;

    import sfir_pkg::*;

    localparam int TAP_NUM    = SFIR_TAP_NUM;
    localparam int DATA_WIDTH = SFIR_DATA_WIDTH;
    localparam int ACC_WIDTH  = SFIR_ACC_WIDTH;
    localparam int IN_DEPTH   = SFIR_IN_DEPTH;
    localparam int OUT_DEPTH  = SFIR_OUT_DEPTH;
    localparam int LATENCY    = TAP_NUM + 3;
    localparam int WAIT_LIMIT = 2000;
    localparam int SMP_MAX    = 2 ** (DATA_WIDTH - 1) - 1;
    localparam int SMP_MIN    = -(2 ** (DATA_WIDTH - 1));
    localparam int SINK_ALWAYS = 0;
    localparam int SINK_RANDOM = 1;
    localparam int SINK_HOLD   = 2;

    logic                         clk_i;
    logic                         arst_n_i;
    logic                         in_valid_i;
    logic signed [DATA_WIDTH-1:0] in_data_i;
    logic                         in_credit_o;
    logic                         out_valid_o;
    logic signed [ACC_WIDTH-1:0]  out_data_o;
    logic                         out_credit_i;

    logic [31:0] stim_seed;
    logic [31:0] sink_seed;
    int sink_mode;
    int in_credits;
    int outstanding;
    int granted_total;
    int valid_total;
    int sent_count;
    int recv_count;
    int check_count;
    int err_count;
    int test_err_start;
    bit run_over;
    int hist [$];
    logic signed [ACC_WIDTH-1:0] exp_q [$];
    logic signed [ACC_WIDTH-1:0] got_q [$];

    sfir_top #(
        .TAP_NUM   (TAP_NUM),
        .DATA_WIDTH(DATA_WIDTH),
        .COEF_WIDTH(SFIR_COEF_WIDTH),
        .ACC_WIDTH (ACC_WIDTH),
        .IN_DEPTH  (IN_DEPTH),
        .OUT_DEPTH (OUT_DEPTH),
        .COEF      (SFIR_COEF)
    ) UUT (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_credit_o (in_credit_o),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_credit_i(out_credit_i)
    );

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // the response is the coefficient set followed by its mirror image.
    function automatic int coef_at(input int m);
        if (m < TAP_NUM) begin
            return SFIR_COEF[m];
        end else begin
            return SFIR_COEF[2 * TAP_NUM - 1 - m];
        end
    endfunction

    function automatic longint fir_ref(input int n);
        longint acc;
        acc = 0;
        for (int m = 0; m < 2 * TAP_NUM; m++) begin
            if (n - m >= 0) begin
                acc += longint'(coef_at(m)) * longint'(hist[n - m]);
            end
        end
        return acc;
    endfunction

    task automatic finish_run();
        if (!run_over) begin
            run_over = 1'b1;
            $display("%0d checks, %0d errors", check_count, err_count);
            if (err_count == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    endtask

    task automatic report_error(input string msg);
        err_count++;
        $display("ERROR: %s", msg);
    endtask

    task automatic timeout_abort(input string what);
        report_error($sformatf("timed out while waiting for %s", what));
        finish_run();
    endtask

    task automatic check_result(input logic signed [ACC_WIDTH-1:0] got,
                                input logic signed [ACC_WIDTH-1:0] exp, input int idx);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("FAILED out_data_o result %0d: got %h, expected %h", idx, got, exp);
        end
    endtask

    task automatic check_credit(input int got, input int exp, input string sig,
                                input string what);
        check_count++;
        if (got != exp) begin
            err_count++;
            $display("FAILED %s %s: got %h, expected %h", sig, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("%-18s finished with %0d errors", name, err_count - test_err_start);
        test_err_start = err_count;
    endtask

    // outputs are read at the rising edge, where the DUT consumes them.
    always @(posedge clk_i) begin
        if (arst_n_i) begin
            if (in_credit_o) begin
                in_credits++;
                if (in_credits > IN_DEPTH) begin
                    report_error("the sender got back more credits than the input FIFO holds");
                end
            end
            if (out_valid_o) begin
                valid_total++;
                outstanding--;
                if (valid_total > granted_total) begin
                    report_error("out_valid_o fired without a sink credit");
                end
                got_q.push_back(out_data_o);
                if (exp_q.size() == 0) begin
                    report_error("a result arrived with no expected value");
                end else begin
                    check_result(out_data_o, exp_q.pop_front(), recv_count);
                end
                recv_count++;
            end
        end
    end

    // the sink grants a credit only for a free slot on its own side.
    always @(negedge clk_i) begin
        if (!arst_n_i) begin
            out_credit_i = 1'b0;
            outstanding  = 0;
        end else begin
            sink_seed    = lcg_step(sink_seed);
            out_credit_i = 1'b0;
            if (outstanding < OUT_DEPTH) begin
                if (sink_mode == SINK_ALWAYS || (sink_mode == SINK_RANDOM && sink_seed[20])) begin
                    out_credit_i = 1'b1;
                    outstanding++;
                    granted_total++;
                end
            end
        end
    end

    task automatic apply_reset();
        arst_n_i = 1'b0;
        repeat (16) @(negedge clk_i);
        in_credits    = IN_DEPTH;
        granted_total = 0;
        valid_total   = 0;
        sent_count    = 0;
        recv_count    = 0;
        hist.delete();
        exp_q.delete();
        got_q.delete();
        // the first results leave the pipeline before any sample reaches them.
        for (int i = 0; i < LATENCY; i++) begin
            exp_q.push_back('0);
        end
        arst_n_i = 1'b1;
    endtask

    task automatic send_sample(input int v);
        int waited;
        longint y;
        logic signed [ACC_WIDTH-1:0] y_acc;
        waited = 0;
        while (in_credits == 0) begin
            @(negedge clk_i);
            waited++;
            if (waited > WAIT_LIMIT) begin
                timeout_abort("an input credit");
            end
        end
        in_valid_i = 1'b1;
        in_data_i  = DATA_WIDTH'(v);
        in_credits--;
        hist.push_back(v);
        y     = fir_ref(sent_count);
        y_acc = ACC_WIDTH'(y);
        if (longint'(y_acc) != y) begin
            report_error("the exact filter output does not fit the result width");
        end
        exp_q.push_back(y_acc);
        sent_count++;
        @(negedge clk_i);
        in_valid_i = 1'b0;
    endtask

    task automatic send_const(input int v, input int count);
        for (int i = 0; i < count; i++) begin
            send_sample(v);
        end
    endtask

    task automatic send_random(input int count, input bit gaps);
        for (int i = 0; i < count; i++) begin
            stim_seed = lcg_step(stim_seed);
            send_sample(int'($signed(stim_seed[31:32-DATA_WIDTH])));
            if (gaps && stim_seed[3]) begin
                repeat (int'(stim_seed[9:8]) + 1) @(negedge clk_i);
            end
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (recv_count != sent_count) begin
            @(negedge clk_i);
            waited++;
            if (waited > WAIT_LIMIT) begin
                timeout_abort("the stream to drain");
            end
        end
        check_credit(in_credits, IN_DEPTH, "in_credit_o", "sender credits after drain");
    endtask

    task automatic check_impulse(input int len);
        logic signed [ACC_WIDTH-1:0] exp;
        for (int k = 0; k < len; k++) begin
            if (k >= LATENCY && k < LATENCY + TAP_NUM) begin
                exp = ACC_WIDTH'(SFIR_COEF[k - LATENCY]);
            end else if (k >= LATENCY + TAP_NUM && k < LATENCY + 2 * TAP_NUM) begin
                exp = ACC_WIDTH'(SFIR_COEF[LATENCY + 2 * TAP_NUM - 1 - k]);
            end else begin
                exp = '0;
            end
            check_result(got_q[k], exp, k);
        end
    endtask

    initial begin
        clk_i          = 1'b0;
        arst_n_i       = 1'b0;
        in_valid_i     = 1'b0;
        in_data_i      = '0;
        out_credit_i   = 1'b0;
        stim_seed      = 32'h1cb1ca14;
        sink_seed      = ~32'h1cb1ca14;
        sink_mode      = SINK_ALWAYS;
        outstanding    = 0;
        check_count    = 0;
        err_count      = 0;
        test_err_start = 0;
        run_over       = 1'b0;
        apply_reset();

        send_sample(1);
        send_const(0, LATENCY + 2 * TAP_NUM + 2);
        wait_drained();
        check_impulse(sent_count);
        end_test("impulse");

        sink_mode = SINK_RANDOM;
        send_random(200, 1'b1);
        wait_drained();
        end_test("random stream");

        sink_mode = SINK_ALWAYS;
        send_random(60, 1'b0);
        wait_drained();
        end_test("input credits");

        sink_mode = SINK_HOLD;
        fork
            send_random(24, 1'b0);
            begin
                repeat (80) @(negedge clk_i);
                check_credit(in_credits, 0, "in_credit_o",
                             "sender credits while the sink holds back");
                check_credit(valid_total, granted_total, "out_valid_o",
                             "results against sink credits");
                sink_mode = SINK_ALWAYS;
            end
        join
        wait_drained();
        end_test("back-pressure");

        send_const(SMP_MIN, 20);
        send_const(SMP_MAX, 20);
        // signs follow the response so that the sum peaks at one phase.
        for (int i = 0; i < 2 * TAP_NUM + 8; i++) begin
            send_sample((coef_at((2 * TAP_NUM - 1) - (i % (2 * TAP_NUM))) >= 0) ? SMP_MAX : SMP_MIN);
        end
        wait_drained();
        end_test("extremes");

        sink_mode = SINK_RANDOM;
        send_random(10, 1'b1);
        apply_reset();
        sink_mode = SINK_ALWAYS;
        send_random(40, 1'b1);
        wait_drained();
        end_test("reset mid-stream");

        finish_run();
    end

endmodule

//--- compile.f
logic/sfir_pkg.sv
logic/sfir_input_buffer.sv
logic/sfir_delay_line.sv
logic/sfir_tap.sv
logic/sfir_output_buffer.sv
logic/sfir_top.sv
dv/sfir_tb.sv

//--- Makefile
# Verilator build and run of the FIR testbench, every variable can be set on the command line.
VERILATOR ?= verilator
TOP       ?= sfir_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and scan $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
